//--- hdl/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // fetch types
    ////////////////////////////////////////////////////////////////////////////

    // byte address without its low 4 bits, one 16-byte line per step
    typedef logic [27:0] fip_t;

    typedef logic [127:0] line_t;   // one cache line

    // fill FSM, one miss at a time
    typedef enum logic [1:0] {
        FILL_IDLE = 2'd0,   // no miss being served
        FILL_REQ  = 2'd1,   // request strobe out this cycle
        FILL_WAIT = 2'd2    // waiting on the data strobe
    } fill_state_t;

endpackage

//--- hdl/fill_if.sv
interface fill_if #(
    parameter int INDEX_BITS = 4
);
    import fetch_pkg::*;

    localparam int TAG_BITS = $bits(fip_t) - 1 - INDEX_BITS;

    logic                  we;      // write strobe, bank samples at posedge
    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    line_t                 line;

    modport filler (
        output we,
        output index,
        output tag,
        output line
    );

    modport bank (
        input we,
        input index,
        input tag,
        input line
    );

endinterface

//--- hdl/fetch_address.sv
module fetch_address #(
    parameter bit PARITY = 1'b0
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic [31:0]     init_addr_i,
    input  logic            is_init_i,
    input  logic            resteer_i,
    input  fetch_pkg::fip_t resteer_fip_i,
    input  logic            br_taken_i,
    input  fetch_pkg::fip_t br_fip_i,
    input  logic            advance_i,
    input  logic            hold_i,
    output fetch_pkg::fip_t fip_o
);
    import fetch_pkg::*;

    fip_t cf_fip;           // control-flow target, not yet aligned
    fip_t cf_fip_aligned;
    logic is_cf;
    logic adv_ok;
    fip_t fip_q;

    ////////////////////////////////////////////////////////////////////////////
    // control-flow select
    ////////////////////////////////////////////////////////////////////////////

    assign is_cf = is_init_i | resteer_i | br_taken_i;

    // init over resteer over branch
    always_comb begin
        if (is_init_i) begin
            cf_fip = init_addr_i[31:4];     // drop byte offset
        end else if (resteer_i) begin
            cf_fip = resteer_fip_i;
        end else begin
            cf_fip = br_fip_i;
        end
    end

    // target of the wrong parity moves up to the next line of ours
    assign cf_fip_aligned = (cf_fip[0] != PARITY) ? cf_fip + fip_t'(1) : cf_fip;

    ////////////////////////////////////////////////////////////////////////////
    // address register
    ////////////////////////////////////////////////////////////////////////////

    assign adv_ok = advance_i & ~hold_i;   // decoder took the pair, no fill pending

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fip_q <= fip_t'(PARITY);        // line 0 even, line 1 odd
        end else if (is_cf) begin
            fip_q <= cf_fip_aligned;        // loads even under hold
        end else if (adv_ok) begin
            fip_q <= fip_q + fip_t'(2);     // skip the other bank's line
        end
    end

    assign fip_o = fip_q;

    // register never leaves its own bank
    a_parity_kept: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        fip_o[0] == PARITY
    );

endmodule

//--- hdl/icache_bank.sv
module icache_bank #(
    parameter int INDEX_BITS = 4
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  fetch_pkg::fip_t  fip_i,
    fill_if.bank             fill,
    output fetch_pkg::line_t line_o,
    output logic             miss_o
);
    import fetch_pkg::*;

    localparam int LINES    = 2 ** INDEX_BITS;
    localparam int TAG_BITS = $bits(fip_t) - 1 - INDEX_BITS;

    line_t                 line_mem [LINES];
    logic [TAG_BITS-1:0]   tag_mem  [LINES];
    logic [LINES-1:0]      valid_q;

    logic [INDEX_BITS-1:0] rd_index;
    logic [TAG_BITS-1:0]   rd_tag;
    logic                  tag_hit;

    ////////////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////////////

    // bit 0 is the parity, index starts above it
    assign rd_index = fip_i[INDEX_BITS:1];
    assign rd_tag   = fip_i[$bits(fip_t)-1:INDEX_BITS+1];

    assign tag_hit = (tag_mem[rd_index] == rd_tag);

    // same cycle as the fip, no output register
    assign line_o = line_mem[rd_index];
    assign miss_o = ~valid_q[rd_index] | ~tag_hit;

    ////////////////////////////////////////////////////////////////////////////
    // fill write
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;                  // whole bank empty
        end else if (fill.we) begin
            valid_q[fill.index] <= 1'b1;
        end
    end

    // data and tag arrays
    always_ff @(posedge clk) begin
        if (fill.we) begin
            line_mem[fill.index] <= fill.line;
            tag_mem[fill.index]  <= fill.tag;
        end
    end

    // fill unit must present a clean index with the strobe
    a_fill_index_known: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        fill.we |-> !$isunknown(fill.index)
    );

endmodule

//--- hdl/fill_unit.sv
module fill_unit #(
    parameter int INDEX_BITS = 4
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  fetch_pkg::fip_t  fip_even_i,
    input  fetch_pkg::fip_t  fip_odd_i,
    input  logic             miss_even_i,
    input  logic             miss_odd_i,
    fill_if.filler           fill_even,
    fill_if.filler           fill_odd,
    output logic             hold_o,
    output logic             fill_req_o,
    output fetch_pkg::fip_t  fill_addr_o,
    input  logic             fill_valid_i,
    input  fetch_pkg::line_t fill_line_i
);
    import fetch_pkg::*;

    fill_state_t state_q;
    fill_state_t state_d;
    fip_t        addr_q;        // line being filled
    logic        to_odd_q;      // target bank of that line
    logic        any_miss;
    logic        start;
    logic        wr;

    assign any_miss = miss_even_i | miss_odd_i;
    assign start    = (state_q == FILL_IDLE) & any_miss;
    assign wr       = (state_q == FILL_WAIT) & fill_valid_i;

    ////////////////////////////////////////////////////////////////////////////
    // fill FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            FILL_IDLE: if (any_miss) state_d = FILL_REQ;
            FILL_REQ:  state_d = FILL_WAIT;     // strobe is one cycle
            FILL_WAIT: if (fill_valid_i) state_d = FILL_IDLE;
            default:   state_d = FILL_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= FILL_IDLE;
            to_odd_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start) begin
                to_odd_q <= ~miss_even_i;   // even wins when both miss
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= miss_even_i ? fip_even_i : fip_odd_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory side and bank writes
    ////////////////////////////////////////////////////////////////////////////

    assign fill_req_o  = (state_q == FILL_REQ);
    assign fill_addr_o = addr_q;

    // stall from the first miss cycle through the write cycle
    assign hold_o = any_miss | (state_q != FILL_IDLE);

    assign fill_even.we    = wr & ~to_odd_q;
    assign fill_even.index = addr_q[INDEX_BITS:1];
    assign fill_even.tag   = addr_q[$bits(fip_t)-1:INDEX_BITS+1];
    assign fill_even.line  = fill_line_i;

    assign fill_odd.we     = wr & to_odd_q;
    assign fill_odd.index  = addr_q[INDEX_BITS:1];
    assign fill_odd.tag    = addr_q[$bits(fip_t)-1:INDEX_BITS+1];
    assign fill_odd.line   = fill_line_i;

    // request is a single pulse followed by the wait
    a_req_pulse: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        fill_req_o |=> !fill_req_o && state_q == FILL_WAIT
    );

    // memory only answers an outstanding request
    a_no_valid_idle: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        state_q == FILL_IDLE |-> !fill_valid_i
    );

endmodule

//--- hdl/fetch_top.sv
module fetch_top #(
    parameter int INDEX_BITS = 4
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic [31:0]      init_addr_i,
    input  logic             is_init_i,
    input  logic             resteer_i,
    input  fetch_pkg::fip_t  resteer_fip_i,
    input  logic             br_taken_i,
    input  fetch_pkg::fip_t  br_fip_i,
    input  logic             advance_i,
    input  logic             fill_valid_i,
    input  fetch_pkg::line_t fill_line_i,
    output fetch_pkg::line_t line_even_o,
    output fetch_pkg::line_t line_odd_o,
    output logic             miss_even_o,
    output logic             miss_odd_o,
    output fetch_pkg::fip_t  fip_even_o,
    output fetch_pkg::fip_t  fip_odd_o,
    output logic             fill_req_o,
    output fetch_pkg::fip_t  fill_addr_o
);

    logic hold;     // fill in progress, blocks advance

    fill_if #(.INDEX_BITS(INDEX_BITS)) u_fill_even_if ();
    fill_if #(.INDEX_BITS(INDEX_BITS)) u_fill_odd_if ();

    ////////////////////////////////////////////////////////////////////////////
    // address registers
    ////////////////////////////////////////////////////////////////////////////

    fetch_address #(.PARITY(1'b0)) u_fetch_even (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .init_addr_i   (init_addr_i),
        .is_init_i     (is_init_i),
        .resteer_i     (resteer_i),
        .resteer_fip_i (resteer_fip_i),
        .br_taken_i    (br_taken_i),
        .br_fip_i      (br_fip_i),
        .advance_i     (advance_i),
        .hold_i        (hold),
        .fip_o         (fip_even_o)
    );

    fetch_address #(.PARITY(1'b1)) u_fetch_odd (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .init_addr_i   (init_addr_i),
        .is_init_i     (is_init_i),
        .resteer_i     (resteer_i),
        .resteer_fip_i (resteer_fip_i),
        .br_taken_i    (br_taken_i),
        .br_fip_i      (br_fip_i),
        .advance_i     (advance_i),
        .hold_i        (hold),
        .fip_o         (fip_odd_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // banks and fill
    ////////////////////////////////////////////////////////////////////////////

    icache_bank #(.INDEX_BITS(INDEX_BITS)) u_bank_even (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .fip_i   (fip_even_o),
        .fill    (u_fill_even_if.bank),
        .line_o  (line_even_o),
        .miss_o  (miss_even_o)
    );

    icache_bank #(.INDEX_BITS(INDEX_BITS)) u_bank_odd (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .fip_i   (fip_odd_o),
        .fill    (u_fill_odd_if.bank),
        .line_o  (line_odd_o),
        .miss_o  (miss_odd_o)
    );

    fill_unit #(.INDEX_BITS(INDEX_BITS)) u_fill_unit (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .fip_even_i   (fip_even_o),
        .fip_odd_i    (fip_odd_o),
        .miss_even_i  (miss_even_o),
        .miss_odd_i   (miss_odd_o),
        .fill_even    (u_fill_even_if.filler),
        .fill_odd     (u_fill_odd_if.filler),
        .hold_o       (hold),
        .fill_req_o   (fill_req_o),
        .fill_addr_o  (fill_addr_o),
        .fill_valid_i (fill_valid_i),
        .fill_line_i  (fill_line_i)
    );

endmodule

//--- tests/fetch_tb.sv
module fetch_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import fetch_pkg::*;

    localparam int INDEX_BITS = 4;
    localparam int LINES = 2 ** INDEX_BITS;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic [31:0] init_addr_i;
    logic        is_init_i, resteer_i, br_taken_i, advance_i, fill_valid_i;
    fip_t        resteer_fip_i, br_fip_i, fip_even_o, fip_odd_o, fill_addr_o;
    line_t       fill_line_i, line_even_o, line_odd_o;
    logic        miss_even_o, miss_odd_o, fill_req_o;

    logic [35:0] vectors [64];      // op in [35:32], value below
    logic [31:0] key;               // xor key of the memory data
    fip_t        exp_even;
    fip_t        exp_odd;
    logic        res_valid [2][LINES];  // reference copy of what each bank holds
    fip_t        res_fip   [2][LINES];
    int          errors = 0;
    int          tests = 0;
    int          cycles = 0;
    int          limit = 100000;
    int          nvec;

    fetch_top #(.INDEX_BITS(INDEX_BITS)) u_fetch_top (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("run stopped after %0d cycles, fetch never settled", cycles);
            $display("test failed");
            $finish;
        end
    end

    // odd register takes the target or the line above it, even likewise
    function automatic fip_t align(fip_t t, logic parity);
        if (parity) begin
            return t | fip_t'(1);
        end else begin
            return t + fip_t'(t[0]);
        end
    endfunction

    function automatic logic resident(int b, fip_t f);
        return res_valid[b][f[INDEX_BITS:1]] && res_fip[b][f[INDEX_BITS:1]] == f;
    endfunction

    function automatic line_t mem_line(fip_t f);
        return {4{{4'h0, f} ^ key}};
    endfunction

    function automatic string op_name(logic [3:0] op);
        case (op)
            4'h1:    return "init";
            4'h2:    return "resteer";
            4'h3:    return "branch";
            4'h4:    return "advance";
            4'h5:    return "init+resteer+branch";
            4'h6:    return "resteer+branch";
            default: return "stall";
        endcase
    endfunction

    task automatic check(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_outputs;
        check("fip_even_o", 128'(fip_even_o), 128'(exp_even));
        check("fip_odd_o", 128'(fip_odd_o), 128'(exp_odd));
        check("line_even_o", line_even_o, mem_line(exp_even));
        check("line_odd_o", line_odd_o, mem_line(exp_odd));
    endtask

    task automatic clear_controls;
        is_init_i = 1'b0;
        resteer_i = 1'b0;
        br_taken_i = 1'b0;
        advance_i = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////////////////////

    // called at the negedge where fill_req_o is seen
    task automatic serve_fill;
        logic odd;
        fip_t want;
        odd = resident(0, exp_even);            // even bank goes first
        want = odd ? exp_odd : exp_even;
        check("fill_addr_o", 128'(fill_addr_o), 128'(want));
        repeat ($urandom_range(6, 1)) @(negedge clk);
        fill_valid_i = 1'b1;
        fill_line_i = mem_line(fill_addr_o);
        @(negedge clk);
        fill_valid_i = 1'b0;
        res_valid[odd][want[INDEX_BITS:1]] = 1'b1;
        res_fip[odd][want[INDEX_BITS:1]] = want;
        check(odd ? "line_odd_o" : "line_even_o", odd ? line_odd_o : line_even_o,
              mem_line(want));
        check(odd ? "miss_odd_o" : "miss_even_o", 128'(odd ? miss_odd_o : miss_even_o),
              128'(0));
    endtask

    // serve fills until both banks hit, advance pushed while held
    task automatic settle;
        int  reqs;
        int  want_reqs;
        bit  done;
        reqs = 0;
        done = 1'b0;
        want_reqs = int'(!resident(0, exp_even)) + int'(!resident(1, exp_odd));
        while (!done) begin
            if (fill_req_o) begin
                reqs++;
                serve_fill();
            end else if (!miss_even_o && !miss_odd_o) begin
                advance_i = 1'b0;
                done = 1'b1;
            end else begin
                advance_i = 1'b1;               // must be ignored under hold
                @(negedge clk);
            end
        end
        check("fill request count", 128'(reqs), 128'(want_reqs));
    endtask

    task automatic drive_op(logic [3:0] op, logic [31:0] val);
        fip_t t;
        t = val[27:0];
        case (op)
            4'h1, 4'h5: begin
                is_init_i = 1'b1;
                init_addr_i = val;
                t = val[31:4];
                resteer_i = (op == 4'h5);       // losers of the priority select
                br_taken_i = (op == 4'h5);
                resteer_fip_i = t + 28'h40;
                br_fip_i = t + 28'h80;
            end
            4'h2, 4'h6: begin
                resteer_i = 1'b1;
                resteer_fip_i = t;
                br_taken_i = (op == 4'h6);
                br_fip_i = t + 28'h40;
            end
            4'h3: begin
                br_taken_i = 1'b1;
                br_fip_i = t;
            end
            default: advance_i = 1'b1;
        endcase
        if (op == 4'h4) begin
            exp_even = exp_even + fip_t'(2);
            exp_odd = exp_odd + fip_t'(2);
        end else begin
            exp_even = align(t, 1'b0);
            exp_odd = align(t, 1'b1);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          e0;
        logic [3:0]  op;
        logic [31:0] val;
        void'($urandom(32'h3c6a));
        $readmemh("tests/fetch_vectors.txt", vectors);
        nvec = 0;
        while (nvec < 64 && vectors[nvec][35:32] != 4'hf) nvec++;
        limit = nvec * 20 + 200;
        key = vectors[0][31:0];
        for (int i = 0; i < LINES; i++) begin
            res_valid[0][i] = 1'b0;
            res_valid[1][i] = 1'b0;
        end
        clear_controls();
        init_addr_i = '0;
        resteer_fip_i = '0;
        br_fip_i = '0;
        fill_valid_i = 1'b0;
        fill_line_i = '0;
        rst_n_i = 1'b0;
        repeat (3) @(negedge clk);
        rst_n_i = 1'b1;
        exp_even = fip_t'(0);                   // reset lines 0 and 1
        exp_odd = fip_t'(1);
        settle();
        check_outputs();
        tests++;
        $display("reset fill done, %0d errors", errors);
        for (int i = 1; i < nvec; i++) begin
            op = vectors[i][35:32];
            val = vectors[i][31:0];
            e0 = errors;
            if (op == 4'h7) begin
                repeat (val) begin
                    @(negedge clk);
                    check_outputs();            // no advance, nothing moves
                end
            end else begin
                repeat (op == 4'h4 ? val : 32'd1) begin
                    drive_op(op, val);
                    @(negedge clk);
                    clear_controls();
                    settle();
                end
            end
            check_outputs();
            tests++;
            $display("vector %0d %s done, %0d errors", i, op_name(op), errors - e0);
        end
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- tests/fetch_vectors.txt
// one word per line, op in the top hex digit and value in the low eight
// op 0 data key, 1 init byte address, 2 resteer fip, 3 branch fip, 4 advance count,
// 5 init+resteer+branch, 6 resteer+branch, 7 stall cycles, f end of list
0a5c3e1f7
400000002
700000004
100001200
100001210
200000345
300000040
500002000
600000500
400000002
300000012
100000000
200000120
100001200
300000012
f00000000

//--- verilog.f
hdl/fetch_pkg.sv
hdl/fill_if.sv
hdl/fetch_address.sv
hdl/icache_bank.sv
hdl/fill_unit.sv
hdl/fetch_top.sv
tests/fetch_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fetch_tb
FILELIST = verilog.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
